/* logic/prefetch_pkg.sv */
// prefetch shared types: fetch line and half formats, fault codes, queue sizing
package prefetch_pkg;

    // ------------------------------
    // sizing

    localparam int PF_LINE_BYTES = 16;                // one fetch line from memory
    localparam int PF_HALF_BYTES = PF_LINE_BYTES / 2; // one decoder half
    localparam int PF_DEPTH_LOG  = 4;                 // 16 lines in the queue
    localparam int PF_DEPTH      = 1 << PF_DEPTH_LOG;
    localparam int PF_USED_W     = PF_DEPTH_LOG + 1;  // used runs 0..16

    // ------------------------------
    // fault codes, carried in the count field

    localparam logic [3:0] PF_GP_FAULT = 4'd14; // segment limit crossed
    localparam logic [3:0] PF_PF_FAULT = 4'd15; // page fault from the tlb

    // ------------------------------
    // payload formats

    // one half line as the decoder sees it
    typedef struct packed {
        logic [3:0]                   count; // valid bytes 0..8, or fault code
        logic [8*PF_HALF_BYTES-1:0]   bytes; // lowest address in lowest byte
    } pf_half_t;

    // whole fetch line, lo goes out first
    typedef struct packed {
        pf_half_t hi;
        pf_half_t lo;
    } pf_line_t;

endpackage

/* logic/sync_fifo.sv */
// line FIFO with first-word fall-through, synchronous clear and fill level
module sync_fifo (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  sclr,    // flush, wins over rd/wr
    input  logic                                  wr_do,
    input  prefetch_pkg::pf_line_t                wr_data,
    input  logic                                  rd_do,
    output prefetch_pkg::pf_line_t                rd_data, // head, valid when !empty
    output logic                                  empty,
    output logic                                  full,
    output logic [prefetch_pkg::PF_DEPTH_LOG-1:0] used     // wraps to 0 when full
);
    import prefetch_pkg::*;

    // ------------------------------
    // storage and pointers

    pf_line_t                mem [PF_DEPTH];
    logic [PF_DEPTH_LOG-1:0] wr_ptr;
    logic [PF_DEPTH_LOG-1:0] rd_ptr;
    logic [PF_USED_W-1:0]    count;  // 0..16
    logic                    do_wr;
    logic                    do_rd;

    assign do_wr = wr_do && !full;  // overflow dropped, caught below
    assign do_rd = rd_do && !empty;

    assign empty   = (count == '0);
    assign full    = (count == PF_USED_W'(PF_DEPTH));
    assign used    = count[PF_DEPTH_LOG-1:0];
    assign rd_data = mem[rd_ptr];   // fall-through head

    // ------------------------------
    // control

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (sclr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    // payload array, no reset
    always_ff @(posedge clk) begin
        if (do_wr && !sclr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ------------------------------
    // protocol checks

    // the fetch side must stop before the queue fills up
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_do && !sclr) |-> !full)
        else $error("sync_fifo: write while full");

    // decoder side only accepts what is shown
    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_do && !sclr) |-> !empty)
        else $error("sync_fifo: read while empty");

endmodule

/* logic/fetch_limit_check.sv */
// segment limit check: trims fetch lines into halves, raises faults and blocks after them
module fetch_limit_check (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pr_reset,        // flush
    input  logic                   fetch_do,
    input  logic [31:0]            fetch_addr,
    input  logic [127:0]           fetch_data,
    input  logic                   page_fault_do,
    input  logic [31:0]            cs_limit,        // stable while fetching
    output logic                   write_do,
    output prefetch_pkg::pf_line_t write_data,
    output logic                   signal_limit_do,
    output logic                   signal_pf_do
);
    import prefetch_pkg::*;

    logic [32:0] remain;      // bytes left before the limit, up to 2^32
    logic        over_limit;
    logic [3:0]  lo_count;
    logic [3:0]  hi_count;
    pf_line_t    line_next;
    logic        blocked;     // set by first fault, held until flush
    logic        take_pf;
    logic        take_limit;
    logic        take_fetch;

    // ------------------------------
    // trimming

    always_comb begin
        remain     = {1'b0, cs_limit} - {1'b0, fetch_addr} + 33'd1;
        over_limit = fetch_addr > cs_limit;     // remain is garbage then

        // lo half
        if (remain >= 33'(PF_HALF_BYTES)) lo_count = 4'(PF_HALF_BYTES);
        else                              lo_count = remain[3:0];

        // hi half, empty when the limit ends inside lo
        if (remain >= 33'(PF_LINE_BYTES))     hi_count = 4'(PF_HALF_BYTES);
        else if (remain > 33'(PF_HALF_BYTES)) hi_count = 4'(remain - 33'(PF_HALF_BYTES));
        else                                  hi_count = 4'd0;

        line_next.lo.count = lo_count;
        line_next.lo.bytes = fetch_data[63:0];   // bytes pass unchanged
        line_next.hi.count = hi_count;
        line_next.hi.bytes = fetch_data[127:64];
    end

    // page fault wins over a fetch in the same cycle
    assign take_pf    = page_fault_do && !blocked;
    assign take_limit = fetch_do && over_limit && !page_fault_do && !blocked;
    assign take_fetch = fetch_do && !over_limit && !page_fault_do && !blocked;

    // ------------------------------
    // output register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_do        <= 1'b0;
            signal_limit_do <= 1'b0;
            signal_pf_do    <= 1'b0;
            blocked         <= 1'b0;
        end else if (pr_reset) begin   // pending strobes dropped
            write_do        <= 1'b0;
            signal_limit_do <= 1'b0;
            signal_pf_do    <= 1'b0;
            blocked         <= 1'b0;
        end else begin
            write_do        <= take_fetch;
            signal_limit_do <= take_limit;
            signal_pf_do    <= take_pf;
            if (take_pf || take_limit) blocked <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take_fetch) write_data <= line_next;
    end

    // queue sees at most one kind of entry per cycle
    a_strobes_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({write_do, signal_limit_do, signal_pf_do}))
        else $error("fetch_limit_check: output strobes overlap");

endmodule

/* logic/prefetch_queue.sv */
// prefetch queue that stores whole lines and hands them to the decoder half by half
module prefetch_queue (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                pr_reset,        // flush
    input  logic                                signal_limit_do,
    input  logic                                signal_pf_do,
    input  logic                                write_do,
    input  prefetch_pkg::pf_line_t              write_data,
    output logic [prefetch_pkg::PF_USED_W-1:0]  used,            // lines held 0..16
    input  logic                                accept_do,       // only while !accept_empty
    output prefetch_pkg::pf_half_t              accept_data,
    output logic                                accept_empty
);
    import prefetch_pkg::*;

    // ------------------------------
    // fifo write side

    pf_line_t                fault_line;
    pf_line_t                fifo_wr_data;
    logic                    fifo_wr;
    logic                    fifo_rd;
    pf_line_t                head;
    logic                    fifo_empty;
    logic                    fifo_full;
    logic [PF_DEPTH_LOG-1:0] fifo_used;

    // fault entry carries its code in lo and has no data or second half
    always_comb begin
        fault_line          = '0;
        fault_line.lo.count = signal_pf_do ? PF_PF_FAULT : PF_GP_FAULT;
    end

    assign fifo_wr      = write_do || signal_limit_do || signal_pf_do;
    assign fifo_wr_data = (signal_limit_do || signal_pf_do) ? fault_line : write_data;

    // ------------------------------
    // second half tracking

    logic     second_pending;  // hi half of the popped line still owed
    pf_half_t second_half;
    logic     lo_is_fault;
    logic     head_has_hi;

    assign lo_is_fault = (head.lo.count == PF_GP_FAULT) || (head.lo.count == PF_PF_FAULT);
    assign head_has_hi = (head.hi.count != 4'd0) && !lo_is_fault; // empty hi skipped

    // first accept of a line pops it
    assign fifo_rd = accept_do && !second_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)         second_pending <= 1'b0;
        else if (pr_reset)  second_pending <= 1'b0;
        else if (accept_do) second_pending <= !second_pending && head_has_hi; // lo in, hi out
    end

    // holds the hi half while it is owed
    always_ff @(posedge clk) begin
        if (fifo_rd) second_half <= head.hi;
    end

    // ------------------------------
    // decoder side

    assign accept_data  = second_pending ? second_half : head.lo;
    assign accept_empty = fifo_empty && !second_pending;
    assign used         = {fifo_full, fifo_used}; // full means 16

    sync_fifo sync_fifo_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .sclr    (pr_reset),
        .wr_do   (fifo_wr),
        .wr_data (fifo_wr_data),
        .rd_do   (fifo_rd),
        .rd_data (head),
        .empty   (fifo_empty),
        .full    (fifo_full),
        .used    (fifo_used)
    );

    // ------------------------------
    // checks

    // decoder only takes a half that is shown
    a_accept_valid: assert property (@(posedge clk) disable iff (!rst_n)
        accept_do |-> !accept_empty)
        else $error("prefetch_queue: accept while empty");

endmodule

/* logic/prefetch_top.sv */
// prefetch top: limit checker feeding the line queue toward the decoder
module prefetch_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               pr_reset,      // flush all
    // memory side
    input  logic                               fetch_do,
    input  logic [31:0]                        fetch_addr,
    input  logic [127:0]                       fetch_data,
    input  logic                               page_fault_do, // from the tlb
    input  logic [31:0]                        cs_limit,
    // decoder side
    input  logic                               accept_do,
    output prefetch_pkg::pf_half_t             accept_data,
    output logic                               accept_empty,
    output logic [prefetch_pkg::PF_USED_W-1:0] used           // fetch side throttle
);
    import prefetch_pkg::*;

    // ------------------------------
    // checker to queue

    logic     write_do;
    pf_line_t write_data;
    logic     signal_limit_do;
    logic     signal_pf_do;

    fetch_limit_check fetch_limit_check_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .pr_reset        (pr_reset),
        .fetch_do        (fetch_do),
        .fetch_addr      (fetch_addr),
        .fetch_data      (fetch_data),
        .page_fault_do   (page_fault_do),
        .cs_limit        (cs_limit),
        .write_do        (write_do),
        .write_data      (write_data),
        .signal_limit_do (signal_limit_do),
        .signal_pf_do    (signal_pf_do)
    );

    prefetch_queue prefetch_queue_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .pr_reset        (pr_reset),
        .signal_limit_do (signal_limit_do),
        .signal_pf_do    (signal_pf_do),
        .write_do        (write_do),
        .write_data      (write_data),
        .used            (used),
        .accept_do       (accept_do),
        .accept_data     (accept_data),
        .accept_empty    (accept_empty)
    );

endmodule

/* bench/prefetch_tb.sv */
// prefetch queue testbench: random fetches, limit clipping, faults, flush and latency
module prefetch_tb;
    import prefetch_pkg::*;

    // ------------------------------
    // dut signals

    logic                 clk;
    logic                 rst_n;
    logic                 pr_reset;
    logic                 fetch_do;
    logic [31:0]          fetch_addr;
    logic [127:0]         fetch_data;
    logic                 page_fault_do;
    logic [31:0]          cs_limit;
    logic                 accept_do;
    pf_half_t             accept_data;
    logic                 accept_empty;
    logic [PF_USED_W-1:0] used;

    // reset 10 + six tests of at most a few hundred cycles each, large margin
    localparam int max_cycles = 4000;

    pf_half_t exp_q[$];            // halves the decoder should see, in order
    logic     model_blocked;       // mirrors the checker's blocked flag
    string    cur_test;
    int       err_count    = 0;
    int       test_err_base;
    int       halves_taken = 0;    // bumped by the compare process
    int       halves_base;
    int       pass_count   = 0;
    int       fail_count   = 0;
    int       cycle_count  = 0;

    prefetch_top prefetch_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .pr_reset      (pr_reset),
        .fetch_do      (fetch_do),
        .fetch_addr    (fetch_addr),
        .fetch_data    (fetch_data),
        .page_fault_do (page_fault_do),
        .cs_limit      (cs_limit),
        .accept_do     (accept_do),
        .accept_data   (accept_data),
        .accept_empty  (accept_empty),
        .used          (used)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // reference model

    // expected line from the trimming rule
    function automatic pf_line_t ref_line(input logic [31:0] addr, input logic [127:0] data,
                                          input logic [31:0] limit);
        pf_line_t line;
        longint   r;                  // bytes before the limit
        line = '0;
        r    = longint'(limit) - longint'(addr) + 1;
        if (addr > limit) begin
            line.lo.count = PF_GP_FAULT; // no data on a fault
        end else begin
            line.lo.count = (r >= 8) ? 4'd8 : 4'(r);
            if (r <= 8) line.hi.count = 4'd0;
            else        line.hi.count = (r - 8 >= 8) ? 4'd8 : 4'(r - 8);
            line.lo.bytes = data[63:0];
            line.hi.bytes = data[127:64];
        end
        return line;
    endfunction

    // lo always goes out, hi only when it holds bytes
    task automatic model_line(input pf_line_t line);
        exp_q.push_back(line.lo);
        if (line.lo.count < PF_GP_FAULT && line.hi.count != 4'd0) exp_q.push_back(line.hi);
    endtask

    function automatic logic [127:0] random_data();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // ------------------------------
    // stimulus helpers

    task automatic step_cycle();
        @(posedge clk);
        #5; // drive just after the edge
    endtask

    task automatic issue_fetch(input logic [31:0] addr, input logic [127:0] data);
        pf_line_t line;
        line = ref_line(addr, data, cs_limit);
        if (!model_blocked) begin
            model_line(line);
            if (line.lo.count == PF_GP_FAULT) model_blocked = 1'b1;
        end
        fetch_addr = addr;
        fetch_data = data;
        fetch_do   = 1'b1;
        step_cycle();
        fetch_do   = 1'b0;
    endtask

    task automatic raise_page_fault();
        pf_half_t fault_half;
        fault_half       = '0;
        fault_half.count = PF_PF_FAULT;
        if (!model_blocked) begin
            exp_q.push_back(fault_half);
            model_blocked = 1'b1;
        end
        page_fault_do = 1'b1;
        step_cycle();
        page_fault_do = 1'b0;
    endtask

    task automatic flush_queue();
        pr_reset = 1'b1;
        step_cycle();
        pr_reset = 1'b0;
        exp_q.delete();
        model_blocked = 1'b0;
    endtask

    // accept whatever is shown until model and dut are both empty
    task automatic drain_halves();
        int guard;
        guard = 0;
        while (!(exp_q.size() == 0 && accept_empty) && guard < 100) begin
            accept_do = !accept_empty;
            step_cycle();
            guard++;
        end
        accept_do = 1'b0;
        assert (exp_q.size() == 0 && accept_empty) else begin
            $display("test %s: queue did not hand out the expected halves, %0d still owed",
                     cur_test, exp_q.size());
            err_count++;
        end
    endtask

    task automatic expect_equal(input string what, input longint exp, input longint act);
        assert (exp == act) else begin
            $display("ERR %s %s expected %0d actual %0d", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_err_base = err_count;
        halves_base   = halves_taken;
    endtask

    task automatic end_test();
        if (err_count == test_err_base) begin
            pass_count++;
            $display("test %s: pass", cur_test);
        end else begin
            fail_count++;
            $display("test %s: fail, %0d errors", cur_test, err_count - test_err_base);
        end
    endtask

    // ------------------------------
    // compare and watchdog

    // outputs are settled by the falling edge, the accept lands on the next rise
    always @(negedge clk) begin : compare_halves
        pf_half_t exp_half;
        if (rst_n && accept_do) begin
            assert (exp_q.size() != 0) else begin
                $display("test %s: decoder took a half that was not expected", cur_test);
                err_count++;
            end
            if (exp_q.size() != 0) begin
                exp_half = exp_q.pop_front();
                assert (accept_data == exp_half) else begin
                    $display("ERR %s expected %h actual %h", cur_test, exp_half, accept_data);
                    err_count++;
                end
            end
            halves_taken++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // test sequence

    initial begin
        rst_n         = 1'b0;
        pr_reset      = 1'b0;
        fetch_do      = 1'b0;
        fetch_addr    = '0;
        fetch_data    = '0;
        page_fault_do = 1'b0;
        cs_limit      = 32'hF000_0000;
        accept_do     = 1'b0;
        model_blocked = 1'b0;
        void'($urandom(46));
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        step_cycle();

        // 1: far below the limit, full halves in order
        start_test("random_lines");
        repeat (2) begin
            repeat (12) issue_fetch($urandom() % 32'h1000_0000, random_data());
            drain_halves();
        end
        expect_equal("halves", 48, halves_taken - halves_base);
        end_test();

        // 2: r runs 1..17, eight single-half lines and nine full ones
        start_test("limit_clip");
        cs_limit = 32'h0000_2000;
        step_cycle();
        for (int k = 0; k <= 16; k++) begin
            issue_fetch(cs_limit - 32'(k), random_data());
            if (k % 8 == 7) drain_halves();
        end
        drain_halves();
        expect_equal("halves", 26, halves_taken - halves_base);
        end_test();

        // 3: fetch past the limit, then blocked until flush
        start_test("limit_fault");
        cs_limit = 32'h0000_1000;
        step_cycle();
        issue_fetch(32'h0000_1001, random_data());
        issue_fetch(32'h0000_0100, random_data()); // ignored
        drain_halves();
        expect_equal("halves", 1, halves_taken - halves_base);
        flush_queue();
        issue_fetch(32'h0000_0100, random_data());
        drain_halves();
        expect_equal("halves after flush", 3, halves_taken - halves_base);
        end_test();

        // 4: page fault entry and the same blocking
        start_test("page_fault");
        raise_page_fault();
        issue_fetch(32'h0000_0200, random_data());
        drain_halves();
        expect_equal("halves", 1, halves_taken - halves_base);
        flush_queue();
        end_test();

        // 5: block, flush, then fill all 16 lines
        start_test("fill_and_flush");
        raise_page_fault();
        repeat (3) step_cycle();
        flush_queue();
        repeat (16) issue_fetch($urandom() % 32'h0000_0800, random_data());
        step_cycle(); // last line visible two cycles after its strobe
        expect_equal("used", 16, longint'(used));
        expect_equal("accept_empty", 0, longint'(accept_empty));
        flush_queue();
        expect_equal("used after flush", 0, longint'(used));
        expect_equal("accept_empty after flush", 1, longint'(accept_empty));
        end_test();

        // 6: latency of a lone line into an empty queue
        start_test("empty_latency");
        expect_equal("accept_empty before", 1, longint'(accept_empty));
        issue_fetch(32'h0000_0040, random_data());
        expect_equal("accept_empty one cycle on", 1, longint'(accept_empty));
        step_cycle();
        expect_equal("accept_empty two cycles on", 0, longint'(accept_empty));
        expect_equal("used", 1, longint'(used));
        drain_halves();
        end_test();

        repeat (4) step_cycle();
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
logic/prefetch_pkg.sv
logic/sync_fifo.sv
logic/fetch_limit_check.sv
logic/prefetch_queue.sv
logic/prefetch_top.sv
bench/prefetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the prefetch queue testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1

obj_dir="obj_dir"
sim_bin="prefetch_sim"
log_file="sim.log"

verilator --binary --timing --assert \
    -f list.f \
    --top-module prefetch_tb \
    -Mdir "$obj_dir" \
    -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$log_file"; then
    exit 1
fi
exit 0
